/* wg_defines.svh */
/*
  Write guard configuration macros
  Widths, table depth and register word offsets
*/
`ifndef WG_DEFINES_SVH
`define WG_DEFINES_SVH

// AXI field widths
`define WG_ID_W      4
`define WG_ADDR_W    32
`define WG_LEN_W     8

// Outstanding write table
`define WG_MAX_TXNS  8
`define WG_CNT_W     16

// Register word offsets
`define WG_REG_BUDGET   3'd0
`define WG_REG_STATUS   3'd1
`define WG_REG_INFO     3'd2
`define WG_REG_LATENCY  3'd3
`define WG_REG_COUNT    3'd4

`endif

/* wg_pkg.sv */
/*
  Write guard shared types
  Field vectors, fault cause encoding and the fault information word
*/
`include "wg_defines.svh"

package wg_pkg;

  typedef logic [`WG_ID_W-1:0]   id_t;
  typedef logic [`WG_ADDR_W-1:0] addr_t;
  typedef logic [`WG_LEN_W-1:0]  len_t;
  typedef logic [`WG_CNT_W-1:0]  cnt_t;

  // Index into the slot pool
  typedef logic [2:0] slot_idx_t;

  typedef enum logic [1:0] {
    NONE     = 2'd0,
    TIMEOUT  = 2'd1,
    UNWANTED = 2'd2
  } fault_cause_e;

  // Stray B response details
  typedef struct packed {
    id_t         id;
    logic [19:0] pad;
    len_t        len;
  } unwanted_info_t;

  // Timeout faults report the address, unwanted ones the ID and length
  typedef union packed {
    addr_t          addr;
    unwanted_info_t unwanted;
  } fault_info_u;

  typedef logic [31:0] reg_word_t;

endpackage

/* wg_write_guard.sv */
/*
  AXI write guard
  Tracks accepted AW requests per ID in linked slots, ages them, retires
  them on B completion and flags timeouts and unwanted B responses
*/
`include "wg_defines.svh"

module wg_write_guard
  import wg_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_ni,
  input  logic         mst_aw_valid_i,
  input  logic         slv_aw_ready_i,
  input  id_t          aw_id_i,
  input  addr_t        aw_addr_i,
  input  len_t         aw_len_i,
  input  logic         b_valid_i,
  input  logic         b_ready_i,
  input  id_t          b_id_i,
  input  cnt_t         budget_i,
  output logic         slv_aw_valid_o,
  output logic         mst_aw_ready_o,
  output logic         fault_valid_o,
  output fault_cause_e fault_cause_o,
  output fault_info_u  fault_info_o,
  output logic         done_valid_o,
  output cnt_t         done_latency_o,
  output logic [3:0]   outstanding_o
);

  // Wide enough for budget times (len + 1)
  typedef logic [`WG_CNT_W+`WG_LEN_W:0] limit_t;

  // Slot pool
  logic [`WG_MAX_TXNS-1:0] slot_free_q, slot_free_d;
  id_t       slot_id_q   [`WG_MAX_TXNS];
  addr_t     slot_addr_q [`WG_MAX_TXNS];
  len_t      slot_len_q  [`WG_MAX_TXNS];
  cnt_t      slot_cnt_q  [`WG_MAX_TXNS];
  slot_idx_t slot_next_q [`WG_MAX_TXNS];
  slot_idx_t slot_next_d [`WG_MAX_TXNS];

  // Head/tail table, one entry per ID
  logic [2**`WG_ID_W-1:0] ht_valid_q, ht_valid_d;
  slot_idx_t ht_head_q [2**`WG_ID_W];
  slot_idx_t ht_head_d [2**`WG_ID_W];
  slot_idx_t ht_tail_q [2**`WG_ID_W];
  slot_idx_t ht_tail_d [2**`WG_ID_W];

  len_t      last_len_q;
  logic      b_hs, retire_en, unwanted, full, can_accept, accept, to_hit;
  slot_idx_t retire_idx, free_idx, new_idx, to_idx, pred_idx;
  id_t       to_id;
  limit_t    limit [`WG_MAX_TXNS];
  logic [`WG_MAX_TXNS-1:0] expired;

  assign b_hs       = b_valid_i && b_ready_i;
  assign retire_en  = b_hs && ht_valid_q[b_id_i];
  assign unwanted   = b_hs && !ht_valid_q[b_id_i];
  assign retire_idx = ht_head_q[b_id_i];

  // AW throttling, a completing B frees a slot for reuse this cycle
  assign full           = ~|slot_free_q;
  assign can_accept     = !full || retire_en;
  assign mst_aw_ready_o = slv_aw_ready_i && can_accept;
  assign slv_aw_valid_o = mst_aw_valid_i && can_accept;
  assign accept         = mst_aw_valid_i && mst_aw_ready_o;

  always_comb begin
    free_idx = '0;
    for (int i = `WG_MAX_TXNS - 1; i >= 0; i--) begin
      if (slot_free_q[i]) begin
        free_idx = slot_idx_t'(i);
      end
    end
  end

  assign new_idx = full ? retire_idx : free_idx;

  // Expiry check, the slot being retired by B is never reported
  always_comb begin
    for (int i = 0; i < `WG_MAX_TXNS; i++) begin
      limit[i]   = limit_t'(budget_i) * limit_t'({1'b0, slot_len_q[i]} + 9'd1);
      expired[i] = !slot_free_q[i] && (budget_i != '0) &&
                   (limit_t'(slot_cnt_q[i]) >= limit[i]) &&
                   !(retire_en && (retire_idx == slot_idx_t'(i)));
    end
  end

  assign to_hit = |expired;

  always_comb begin
    to_idx = '0;
    for (int i = `WG_MAX_TXNS - 1; i >= 0; i--) begin
      if (expired[i]) begin
        to_idx = slot_idx_t'(i);
      end
    end
  end

  assign to_id = slot_id_q[to_idx];

  // Predecessor of the expired slot within its ID list
  always_comb begin
    pred_idx = '0;
    for (int j = 0; j < `WG_MAX_TXNS; j++) begin
      if (!slot_free_q[j] && (slot_id_q[j] == to_id) &&
          (slot_next_q[j] == to_idx) && (ht_tail_q[to_id] != slot_idx_t'(j))) begin
        pred_idx = slot_idx_t'(j);
      end
    end
  end

  // Retire, then unlink the timed-out slot, then append the new write
  always_comb begin
    slot_free_d = slot_free_q;
    slot_next_d = slot_next_q;
    ht_valid_d  = ht_valid_q;
    ht_head_d   = ht_head_q;
    ht_tail_d   = ht_tail_q;

    if (retire_en) begin
      slot_free_d[retire_idx] = 1'b1;
      if (retire_idx == ht_tail_q[b_id_i]) begin
        ht_valid_d[b_id_i] = 1'b0;
      end else begin
        ht_head_d[b_id_i] = slot_next_q[retire_idx];
      end
    end

    if (to_hit) begin
      slot_free_d[to_idx] = 1'b1;
      if (ht_head_d[to_id] == to_idx) begin
        if (ht_tail_d[to_id] == to_idx) begin
          ht_valid_d[to_id] = 1'b0;
        end else begin
          ht_head_d[to_id] = slot_next_q[to_idx];
        end
      end else begin
        slot_next_d[pred_idx] = slot_next_q[to_idx];
        if (ht_tail_d[to_id] == to_idx) begin
          ht_tail_d[to_id] = pred_idx;
        end
      end
    end

    if (accept) begin
      slot_free_d[new_idx] = 1'b0;
      if (ht_valid_d[aw_id_i]) begin
        slot_next_d[ht_tail_d[aw_id_i]] = new_idx;
        ht_tail_d[aw_id_i] = new_idx;
      end else begin
        ht_valid_d[aw_id_i] = 1'b1;
        ht_head_d[aw_id_i]  = new_idx;
        ht_tail_d[aw_id_i]  = new_idx;
      end
    end
  end

  // Timeout takes priority over a stray response
  always_comb begin
    fault_cause_o = NONE;
    fault_info_o  = '0;
    if (to_hit) begin
      fault_cause_o     = TIMEOUT;
      fault_info_o.addr = slot_addr_q[to_idx];
    end else if (unwanted) begin
      fault_cause_o             = UNWANTED;
      fault_info_o.unwanted.id  = b_id_i;
      fault_info_o.unwanted.len = last_len_q;
    end
  end

  assign fault_valid_o  = to_hit || unwanted;
  assign done_valid_o   = retire_en;
  assign done_latency_o = slot_cnt_q[retire_idx] + cnt_t'(1);

  always_comb begin
    outstanding_o = '0;
    for (int i = 0; i < `WG_MAX_TXNS; i++) begin
      if (!slot_free_q[i]) begin
        outstanding_o = outstanding_o + 4'd1;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      slot_free_q <= '1;
      ht_valid_q  <= '0;
      last_len_q  <= '0;
    end else begin
      slot_free_q <= slot_free_d;
      ht_valid_q  <= ht_valid_d;
      if (accept) begin
        last_len_q <= aw_len_i;
      end
    end
  end

  // Link pointers and slot payload
  always_ff @(posedge clk_i) begin
    slot_next_q <= slot_next_d;
    ht_head_q   <= ht_head_d;
    ht_tail_q   <= ht_tail_d;
    if (accept) begin
      slot_id_q[new_idx]   <= aw_id_i;
      slot_addr_q[new_idx] <= aw_addr_i;
      slot_len_q[new_idx]  <= aw_len_i;
    end
    // Age counters saturate at all ones
    for (int i = 0; i < `WG_MAX_TXNS; i++) begin
      if (accept && (new_idx == slot_idx_t'(i))) begin
        slot_cnt_q[i] <= '0;
      end else if (!slot_free_q[i] && (slot_cnt_q[i] != '1)) begin
        slot_cnt_q[i] <= slot_cnt_q[i] + cnt_t'(1);
      end
    end
  end

endmodule

/* wg_regs.sv */
/*
  Write guard register block
  Budget, sticky fault status and info, last latency and outstanding count
*/
`include "wg_defines.svh"

module wg_regs
  import wg_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_ni,
  input  logic         reg_we_i,
  input  logic [2:0]   reg_addr_i,
  input  reg_word_t    reg_wdata_i,
  output reg_word_t    reg_rdata_o,
  input  logic         fault_valid_i,
  input  fault_cause_e fault_cause_i,
  input  fault_info_u  fault_info_i,
  input  logic         done_valid_i,
  input  cnt_t         done_latency_i,
  input  logic [3:0]   outstanding_i,
  output cnt_t         budget_o,
  output logic         fault_clear_o,
  output logic         irq_o,
  output logic         reset_req_o
);

  cnt_t         budget_q;
  cnt_t         latency_q;
  logic         pending_q;
  fault_cause_e cause_q;
  fault_info_u  info_q;
  logic         first_fault;

  // Write 1 to STATUS bit 0 clears the pending fault
  assign fault_clear_o = reg_we_i && (reg_addr_i == `WG_REG_STATUS) && reg_wdata_i[0];

  // Only the first fault after a clear is captured
  assign first_fault = fault_valid_i && (!pending_q || fault_clear_o);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      budget_q  <= '0;
      pending_q <= 1'b0;
      cause_q   <= NONE;
    end else begin
      if (reg_we_i && (reg_addr_i == `WG_REG_BUDGET)) begin
        budget_q <= reg_wdata_i[`WG_CNT_W-1:0];
      end
      if (first_fault) begin
        pending_q <= 1'b1;
        cause_q   <= fault_cause_i;
      end else if (fault_clear_o) begin
        pending_q <= 1'b0;
        cause_q   <= NONE;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (first_fault) begin
      info_q <= fault_info_i;
    end
    if (done_valid_i) begin
      latency_q <= done_latency_i;
    end
  end

  always_comb begin
    reg_rdata_o = '0;
    case (reg_addr_i)
      `WG_REG_BUDGET:  reg_rdata_o = reg_word_t'(budget_q);
      `WG_REG_STATUS:  reg_rdata_o = reg_word_t'({cause_q, pending_q});
      `WG_REG_INFO:    reg_rdata_o = info_q;
      `WG_REG_LATENCY: reg_rdata_o = reg_word_t'(latency_q);
      `WG_REG_COUNT:   reg_rdata_o = reg_word_t'(outstanding_i);
      default:         reg_rdata_o = '0;
    endcase
  end

  assign budget_o = budget_q;

  // Interrupt and reset request follow the sticky pending flag
  assign irq_o       = pending_q;
  assign reset_req_o = pending_q;

endmodule

/* wg_top.sv */
/*
  Write guard top level
  Joins the AW/B guard with its register block
*/
module wg_top
  import wg_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  // AW channel
  input  logic       mst_aw_valid_i,
  input  id_t        aw_id_i,
  input  addr_t      aw_addr_i,
  input  len_t       aw_len_i,
  input  logic       slv_aw_ready_i,
  output logic       slv_aw_valid_o,
  output logic       mst_aw_ready_o,
  // B channel
  input  logic       b_valid_i,
  input  logic       b_ready_i,
  input  id_t        b_id_i,
  // Register port
  input  logic       reg_we_i,
  input  logic [2:0] reg_addr_i,
  input  reg_word_t  reg_wdata_i,
  output reg_word_t  reg_rdata_o,
  output logic       irq_o,
  output logic       reset_req_o
);

  cnt_t         budget;
  logic         fault_valid;
  fault_cause_e fault_cause;
  fault_info_u  fault_info;
  logic         done_valid;
  cnt_t         done_latency;
  logic [3:0]   outstanding;

  wg_write_guard u_guard (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .mst_aw_valid_i (mst_aw_valid_i),
    .slv_aw_ready_i (slv_aw_ready_i),
    .aw_id_i        (aw_id_i),
    .aw_addr_i      (aw_addr_i),
    .aw_len_i       (aw_len_i),
    .b_valid_i      (b_valid_i),
    .b_ready_i      (b_ready_i),
    .b_id_i         (b_id_i),
    .budget_i       (budget),
    .slv_aw_valid_o (slv_aw_valid_o),
    .mst_aw_ready_o (mst_aw_ready_o),
    .fault_valid_o  (fault_valid),
    .fault_cause_o  (fault_cause),
    .fault_info_o   (fault_info),
    .done_valid_o   (done_valid),
    .done_latency_o (done_latency),
    .outstanding_o  (outstanding)
  );

  wg_regs u_regs (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .reg_we_i       (reg_we_i),
    .reg_addr_i     (reg_addr_i),
    .reg_wdata_i    (reg_wdata_i),
    .reg_rdata_o    (reg_rdata_o),
    .fault_valid_i  (fault_valid),
    .fault_cause_i  (fault_cause),
    .fault_info_i   (fault_info),
    .done_valid_i   (done_valid),
    .done_latency_i (done_latency),
    .outstanding_i  (outstanding),
    .budget_o       (budget),
    .fault_clear_o  (),
    .irq_o          (irq_o),
    .reset_req_o    (reset_req_o)
  );

endmodule

/* wg_assert.sv */
/*
  Write guard assertions
  Checks AW throttling, fault cause validity and the outstanding count
*/
`include "wg_defines.svh"

module wg_assert
  import wg_pkg::*;
(
  input logic         clk_i,
  input logic         rst_ni,
  input logic         mst_aw_ready_o,
  input logic         done_valid_o,
  input logic         fault_valid_o,
  input fault_cause_e fault_cause_o,
  input logic [3:0]   outstanding_o
);
  timeunit 1ns;
  timeprecision 1ps;

  // No accept into a full table unless a slot frees this cycle
  full_blocks_aw: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (outstanding_o == 4'(`WG_MAX_TXNS) && !done_valid_o) |-> !mst_aw_ready_o)
    else $error("AW ready high with a full table");

  fault_has_cause: assert property (@(posedge clk_i) disable iff (!rst_ni)
    fault_valid_o |-> (fault_cause_o != NONE))
    else $error("fault pulse with cause NONE");

  count_in_range: assert property (@(posedge clk_i) disable iff (!rst_ni)
    outstanding_o <= 4'(`WG_MAX_TXNS))
    else $error("outstanding count above table depth");

endmodule

bind wg_write_guard wg_assert u_assert (
  .clk_i          (clk_i),
  .rst_ni         (rst_ni),
  .mst_aw_ready_o (mst_aw_ready_o),
  .done_valid_o   (done_valid_o),
  .fault_valid_o  (fault_valid_o),
  .fault_cause_o  (fault_cause_o),
  .outstanding_o  (outstanding_o)
);

/* wg_tb.sv */
/*
  Write guard testbench
  Table-driven AW/B and register stimulus against the top level
*/
`include "wg_defines.svh"

module wg_tb
  import wg_pkg::*;
;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int K_COMPLETE = 0;
  localparam int K_ORDER    = 1;
  localparam int K_TIMEOUT  = 2;
  localparam int K_UNWANTED = 3;
  localparam int K_FULL     = 4;
  localparam int K_STICKY   = 5;
  localparam int TMO        = 2000;

  typedef struct {
    string        name;
    int           kind;
    int           budget;
    id_t          id;
    addr_t        addr;
    len_t         len;
    int           bdelay;
    id_t          bid;
    fault_cause_e cause;
    fault_info_u  info;
    int           latency;
  } row_t;

  logic clk_i = 1'b0;
  logic rst_ni, mst_aw_valid_i, slv_aw_ready_i, b_valid_i, b_ready_i, reg_we_i;
  id_t aw_id_i, b_id_i;
  addr_t aw_addr_i;
  len_t aw_len_i;
  logic [2:0] reg_addr_i;
  reg_word_t reg_wdata_i, reg_rdata_o;
  logic slv_aw_valid_o, mst_aw_ready_o, irq_o, reset_req_o;
  row_t rows[$];
  int seed = 32'h2a2f5ce2;
  int cyc = 0;
  int accept_cyc;

  wg_top dut (.*);

  always #4 clk_i = ~clk_i;

  // Rising edge count, times accepts and completions
  always @(posedge clk_i) cyc++;

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("TB FAILED");
    $fatal(1);
  endtask

  task automatic check_word(input string name, input reg_word_t exp, input reg_word_t act);
    if (exp !== act)
      stop_run($sformatf("[ERROR] %s: expected %h, actual %h", name, exp, act));
  endtask

  task automatic check_cause(input string name, input fault_cause_e exp,
                             input fault_cause_e act);
    if (exp !== act)
      stop_run($sformatf("[ERROR] %s: expected %s, actual %s", name, exp.name(), act.name()));
  endtask

  task automatic check_info(input string name, input fault_info_u exp, input fault_info_u act);
    if (exp !== act)
      stop_run($sformatf("[ERROR] %s: expected %h, actual %h", name, exp, act));
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (exp !== act)
      stop_run($sformatf("[ERROR] %s: expected %b, actual %b", name, exp, act));
  endtask

  task automatic write_reg(input logic [2:0] addr, input reg_word_t data);
    @(posedge clk_i);
    #1;
    reg_we_i    = 1'b1;
    reg_addr_i  = addr;
    reg_wdata_i = data;
    @(posedge clk_i);
    #1;
    reg_we_i = 1'b0;
  endtask

  task automatic read_reg(input logic [2:0] addr, output reg_word_t data);
    @(posedge clk_i);
    #1;
    reg_addr_i = addr;
    @(negedge clk_i);
    data = reg_rdata_o;
  endtask

  // Returns 1 ns after the accept edge and records that edge
  task automatic send_aw(input id_t id, input addr_t addr, input len_t len);
    int n;
    @(posedge clk_i);
    #1;
    mst_aw_valid_i = 1'b1;
    aw_id_i        = id;
    aw_addr_i      = addr;
    aw_len_i       = len;
    n = 0;
    @(negedge clk_i);
    while (!mst_aw_ready_o) begin
      n++;
      if (n > TMO) stop_run("AW was never accepted");
      @(negedge clk_i);
    end
    @(posedge clk_i);
    #1;
    accept_cyc     = cyc;
    mst_aw_valid_i = 1'b0;
  endtask

  // One-cycle B handshake, called 1 ns after an edge
  task automatic send_b(input id_t id);
    b_valid_i = 1'b1;
    b_id_i    = id;
    @(posedge clk_i);
    #1;
    b_valid_i = 1'b0;
  endtask

  task automatic wait_irq(input int min_cycles);
    int n;
    n = 0;
    while (!irq_o) begin
      @(posedge clk_i);
      #1;
      n++;
      if (n > min_cycles + 50) stop_run("interrupt did not rise in time");
    end
    if (n < min_cycles) stop_run("interrupt rose before the write budget ran out");
  endtask

  task automatic check_fault(input row_t r);
    reg_word_t d;
    check_bit({r.name, " irq"}, 1'b1, irq_o);
    check_bit({r.name, " reset_req"}, 1'b1, reset_req_o);
    read_reg(`WG_REG_STATUS, d);
    check_bit({r.name, " pending"}, 1'b1, d[0]);
    check_cause({r.name, " cause"}, r.cause, fault_cause_e'(d[2:1]));
    read_reg(`WG_REG_INFO, d);
    check_info({r.name, " info"}, r.info, fault_info_u'(d));
    write_reg(`WG_REG_STATUS, 32'h1);
    check_bit({r.name, " irq clear"}, 1'b0, irq_o);
    check_bit({r.name, " reset_req clear"}, 1'b0, reset_req_o);
  endtask

  task automatic add_row(input string name, input int kind, input int budget, input id_t id,
                         input len_t len, input int bdelay, input id_t bid);
    row_t r;
    r.name = name;
    r.kind = kind;
    r.budget = budget;
    r.id = id;
    r.addr = $random(seed);
    r.len = len;
    r.bdelay = bdelay;
    r.bid = bid;
    r.latency = bdelay + 1;
    r.cause = NONE;
    r.info = '0;
    if (kind == K_TIMEOUT || kind == K_STICKY) begin
      r.cause = TIMEOUT;
      r.info.addr = r.addr;
    end else if (kind == K_UNWANTED) begin
      r.cause = UNWANTED;
      r.info.unwanted.id = bid;
      r.info.unwanted.len = len;
    end
    rows.push_back(r);
  endtask

  task automatic run_row(input row_t r);
    reg_word_t d;
    int acc[$];
    int b_end;
    write_reg(`WG_REG_BUDGET, reg_word_t'(r.budget));
    case (r.kind)
      K_COMPLETE: begin
        send_aw(r.id, r.addr, r.len);
        repeat (r.bdelay) @(posedge clk_i);
        #1;
        send_b(r.id);
        read_reg(`WG_REG_LATENCY, d);
        check_word({r.name, " latency"}, reg_word_t'(r.latency), d);
      end
      K_ORDER: begin
        send_aw(r.id, r.addr, 8'd7);
        acc.push_back(accept_cyc);
        send_aw(r.id, r.addr + 32'h40, 8'd7);
        acc.push_back(accept_cyc);
        send_aw(r.id, r.addr + 32'h80, r.len);
        acc.push_back(accept_cyc);
        // Each B retires the oldest write of the ID
        for (int i = 2; i >= 0; i--) begin
          @(posedge clk_i);
          #1;
          send_b(r.id);
          b_end = cyc;
          read_reg(`WG_REG_LATENCY, d);
          check_word({r.name, " oldest first"}, reg_word_t'(b_end - acc.pop_front()), d);
          read_reg(`WG_REG_COUNT, d);
          check_word({r.name, " count step"}, reg_word_t'(i), d);
        end
      end
      K_TIMEOUT, K_STICKY: begin
        send_aw(r.id, r.addr, r.len);
        wait_irq(r.budget * (r.len + 1));
        if (r.kind == K_STICKY) send_b(r.bid);
        check_fault(r);
      end
      K_UNWANTED: begin
        send_aw(r.id, r.addr, r.len);
        send_b(r.id);
        send_b(r.bid);
        @(posedge clk_i);
        #1;
        check_fault(r);
      end
      default: begin
        for (int i = 0; i < `WG_MAX_TXNS; i++) send_aw(id_t'(i), r.addr + i, r.len);
        mst_aw_valid_i = 1'b1;
        aw_id_i = r.id;
        repeat (4) begin
          @(negedge clk_i);
          check_bit({r.name, " ready while full"}, 1'b0, mst_aw_ready_o);
          check_bit({r.name, " valid while full"}, 1'b0, slv_aw_valid_o);
        end
        @(posedge clk_i);
        #1;
        b_valid_i = 1'b1;
        b_id_i = r.bid;
        @(negedge clk_i);
        check_bit({r.name, " ready after B"}, 1'b1, mst_aw_ready_o);
        check_bit({r.name, " valid after B"}, 1'b1, slv_aw_valid_o);
        @(posedge clk_i);
        #1;
        b_valid_i = 1'b0;
        mst_aw_valid_i = 1'b0;
        for (int i = 1; i <= `WG_MAX_TXNS; i++) send_b(id_t'(i));
      end
    endcase
    check_bit({r.name, " no stray irq"}, 1'b0, irq_o);
    read_reg(`WG_REG_COUNT, d);
    check_word({r.name, " count"}, 32'h0, d);
  endtask

  initial begin
    rst_ni = 1'b0;
    mst_aw_valid_i = 1'b0;
    slv_aw_ready_i = 1'b1;
    b_valid_i = 1'b0;
    b_ready_i = 1'b1;
    aw_id_i = '0;
    aw_addr_i = '0;
    aw_len_i = '0;
    b_id_i = '0;
    reg_we_i = 1'b0;
    reg_addr_i = '0;
    reg_wdata_i = '0;
    add_row("in_order", K_COMPLETE, 100, 4'd3, 8'd1, 5, 4'd3);
    add_row("same_id", K_ORDER, 40, 4'd5, 8'd0, 0, 4'd5);
    add_row("timeout", K_TIMEOUT, 6, 4'd2, 8'd2, 0, 4'd2);
    add_row("unwanted", K_UNWANTED, 0, 4'd1, 8'd9, 0, 4'd12);
    add_row("full_table", K_FULL, 0, 4'd8, 8'd0, 0, 4'd0);
    add_row("sticky", K_STICKY, 4, 4'd6, 8'd1, 0, 4'd9);
    repeat (5) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    foreach (rows[i]) run_row(rows[i]);
    $display("TB PASSED");
    $finish;
  end

endmodule

/* files.f */
+incdir+.
wg_pkg.sv
wg_write_guard.sv
wg_regs.sv
wg_top.sv
wg_assert.sv
wg_tb.sv

/* Makefile */
# Verilator build for the AXI write guard testbench

VERILATOR  ?= verilator
FLAGS      ?= --timing --assert
TOP        ?= wg_tb
FILELIST   ?= files.f
OBJ_DIR    ?= obj_dir
PASS_MSG   ?= TB PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(FILELIST) *.sv *.svh
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
